// ==== rtl/render_pkg.sv ====
package render_pkg;

        //////////////////////////////////////////////////
        // widths and alpha weights
        //////////////////////////////////////////////////

        localparam int PIXEL_W   = 32;
        localparam int CHAN_W    = 8;

        // weight of a full source 1 pixel, weights are a and ALPHA_ONE-a
        localparam int ALPHA_ONE = 256;

        // three argb colour channels or six rgb565 fields
        localparam int SLOTS     = 6;

        //////////////////////////////////////////////////
        // pixel word layouts
        //////////////////////////////////////////////////

        typedef struct packed {
                logic [CHAN_W-1:0] a;
                logic [CHAN_W-1:0] r;
                logic [CHAN_W-1:0] g;
                logic [CHAN_W-1:0] b;
        } argb8888_t;

        typedef struct packed {
                logic [4:0] r;
                logic [5:0] g;
                logic [4:0] b;
        } rgb565_t;

        typedef struct packed {
                rgb565_t hi;
                rgb565_t lo;
        } rgb565_pair_t;

        // same 32 bits, decoded by the colour format bit
        typedef union packed {
                argb8888_t    argb;
                rgb565_pair_t rgb;
        } pixel_word_t;

        // one weighted channel, 8 bit colour times 9 bit weight
        typedef logic [15:0] blend_prod_t;

endpackage

// ==== rtl/pixel_fifo.sv ====
`timescale 1ns/1ns

module pixel_fifo
        import render_pkg::*;
#(
        parameter int DEPTH      = 16,
        parameter int ALMOST_GAP = 2
) (
        input  logic        i_wire_clock,
        input  logic        i_rst,
        input  logic        i_write,
        input  pixel_word_t i_data,
        input  logic        i_read,
        output pixel_word_t o_data,
        output logic        o_full,
        output logic        o_almost_full,
        output logic        o_empty
);

        localparam int AW    = $clog2(DEPTH);
        localparam int CNT_W = AW + 1;

        // almost full once fewer than ALMOST_GAP+1 slots are free
        localparam logic [CNT_W-1:0] FULL_LEVEL = CNT_W'(DEPTH);
        localparam logic [CNT_W-1:0] AF_LEVEL   = CNT_W'(DEPTH - ALMOST_GAP - 1);

        pixel_word_t        mem [DEPTH];
        logic [AW-1:0]      wr_ptr;
        logic [AW-1:0]      rd_ptr;
        logic [CNT_W-1:0]   count;

        //////////////////////////////////////////////////
        // storage
        //////////////////////////////////////////////////

        always_ff @(posedge i_wire_clock) begin
                if (i_write) begin
                        mem[wr_ptr] <= i_data;
                end
        end

        // first word fall through
        assign o_data = mem[rd_ptr];

        //////////////////////////////////////////////////
        // pointers and occupancy
        //////////////////////////////////////////////////

        always_ff @(posedge i_wire_clock) begin
                if (i_rst) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (i_write) begin
                                wr_ptr <= wr_ptr + 1'b1;
                        end
                        if (i_read) begin
                                rd_ptr <= rd_ptr + 1'b1;
                        end
                        case ({i_write, i_read})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;
                        endcase
                end
        end

        // flags straight from the count
        assign o_full        = (count == FULL_LEVEL);
        assign o_almost_full = (count > AF_LEVEL);
        assign o_empty       = (count == '0);

endmodule

// ==== rtl/blend_multiply.sv ====
`timescale 1ns/1ns

module blend_multiply
        import render_pkg::*;
(
        input  logic                          i_wire_clock,
        input  logic                          i_rst,
        input  logic                          i_argb_mode,
        input  logic [CHAN_W-1:0]             i_blend_alpha,
        input  pixel_word_t                   i_src1,
        input  pixel_word_t                   i_src2,
        input  logic                          i_src1_empty,
        input  logic                          i_src2_empty,
        input  logic                          i_out_almost_full,
        output logic                          o_pop,
        output blend_prod_t [SLOTS-1:0]       o_prod1,
        output blend_prod_t [SLOTS-1:0]       o_prod2,
        output logic [CHAN_W-1:0]             o_alpha,
        output logic                          o_valid
);

        logic [CHAN_W-1:0]              alpha_sel;
        logic [CHAN_W:0]                w1;
        logic [CHAN_W:0]                w2;
        logic [SLOTS-1:0][CHAN_W-1:0]   chan1;
        logic [SLOTS-1:0][CHAN_W-1:0]   chan2;

        // spread one word over the channel slots
        // argb: b g r a, rgb565: lo b g r then hi b g r
        function automatic logic [SLOTS-1:0][CHAN_W-1:0] slot_chan(
                input pixel_word_t w,
                input logic        argb
        );
                logic [SLOTS-1:0][CHAN_W-1:0] c;
                c = '0;
                if (argb) begin
                        c[0] = w.argb.b;
                        c[1] = w.argb.g;
                        c[2] = w.argb.r;
                        c[3] = w.argb.a;
                end else begin
                        c[0] = CHAN_W'(w.rgb.lo.b);
                        c[1] = CHAN_W'(w.rgb.lo.g);
                        c[2] = CHAN_W'(w.rgb.lo.r);
                        c[3] = CHAN_W'(w.rgb.hi.b);
                        c[4] = CHAN_W'(w.rgb.hi.g);
                        c[5] = CHAN_W'(w.rgb.hi.r);
                end
                return c;
        endfunction

        // both sources ready and room for everything in flight
        assign o_pop = !i_src1_empty && !i_src2_empty && !i_out_almost_full;

        assign alpha_sel = i_argb_mode ? i_src1.argb.a : i_blend_alpha;
        assign w1        = {1'b0, alpha_sel};
        assign w2        = (CHAN_W+1)'(ALPHA_ONE) - w1;

        assign chan1 = slot_chan(i_src1, i_argb_mode);
        assign chan2 = slot_chan(i_src2, i_argb_mode);

        //////////////////////////////////////////////////
        // stage 1 registers
        //////////////////////////////////////////////////

        always_ff @(posedge i_wire_clock) begin
                for (int k = 0; k < SLOTS; k++) begin
                        o_prod1[k] <= 16'(chan1[k]) * 16'(w1);
                        o_prod2[k] <= 16'(chan2[k]) * 16'(w2);
                end
                o_alpha <= i_src1.argb.a;
        end

        always_ff @(posedge i_wire_clock) begin
                if (i_rst) begin
                        o_valid <= 1'b0;
                end else begin
                        o_valid <= o_pop;
                end
        end

endmodule

// ==== rtl/blend_combine.sv ====
`timescale 1ns/1ns

module blend_combine
        import render_pkg::*;
(
        input  logic                          i_wire_clock,
        input  logic                          i_rst,
        input  logic                          i_argb_mode,
        input  blend_prod_t [SLOTS-1:0]       i_prod1,
        input  blend_prod_t [SLOTS-1:0]       i_prod2,
        input  logic [CHAN_W-1:0]             i_alpha,
        input  logic                          i_valid,
        output logic                          o_write,
        output pixel_word_t                   o_data
);

        blend_prod_t [SLOTS-1:0]        sum;
        logic [SLOTS-1:0][CHAN_W-1:0]   chan;
        pixel_word_t                    word;

        // weights add up to 256 so the sum never overflows 16 bits
        always_comb begin
                for (int k = 0; k < SLOTS; k++) begin
                        sum[k]  = i_prod1[k] + i_prod2[k];
                        chan[k] = sum[k][15:8];
                end
        end

        //////////////////////////////////////////////////
        // repack by colour format
        //////////////////////////////////////////////////

        always_comb begin
                word = '0;
                if (i_argb_mode) begin
                        // alpha passes through from source 1
                        word.argb.a = i_alpha;
                        word.argb.r = chan[2];
                        word.argb.g = chan[1];
                        word.argb.b = chan[0];
                end else begin
                        word.rgb.lo.b = chan[0][4:0];
                        word.rgb.lo.g = chan[1][5:0];
                        word.rgb.lo.r = chan[2][4:0];
                        word.rgb.hi.b = chan[3][4:0];
                        word.rgb.hi.g = chan[4][5:0];
                        word.rgb.hi.r = chan[5][4:0];
                end
        end

        //////////////////////////////////////////////////
        // stage 2 registers, feed the output fifo
        //////////////////////////////////////////////////

        always_ff @(posedge i_wire_clock) begin
                o_data <= word;
        end

        always_ff @(posedge i_wire_clock) begin
                if (i_rst) begin
                        o_write <= 1'b0;
                end else begin
                        o_write <= i_valid;
                end
        end

endmodule

// ==== rtl/render_blend_top.sv ====
`timescale 1ns/1ns

module render_blend_top
        import render_pkg::*;
#(
        parameter int DEPTH      = 16,
        parameter int ALMOST_GAP = 2
) (
        input  logic                i_wire_clock,
        input  logic                i_rst,
        input  logic                i_argb_mode,
        input  logic [PIXEL_W-1:0]  i_blend,
        input  logic                i_src1_write,
        input  pixel_word_t         i_src1_data,
        output logic                o_src1_full,
        input  logic                i_src2_write,
        input  pixel_word_t         i_src2_data,
        output logic                o_src2_full,
        input  logic                i_out_read,
        output pixel_word_t         o_out_data,
        output logic                o_out_empty
);

        pixel_word_t                src1_head;
        pixel_word_t                src2_head;
        logic                       src1_empty;
        logic                       src2_empty;
        logic                       pop;
        logic                       out_almost_full;
        blend_prod_t [SLOTS-1:0]    prod1;
        blend_prod_t [SLOTS-1:0]    prod2;
        logic [CHAN_W-1:0]          alpha;
        logic                       valid;
        logic                       out_write;
        pixel_word_t                out_word;

        //////////////////////////////////////////////////
        // source fifos
        //////////////////////////////////////////////////

        pixel_fifo #(.DEPTH(DEPTH), .ALMOST_GAP(ALMOST_GAP)) u_src1_fifo (
                .i_wire_clock  (i_wire_clock),
                .i_rst         (i_rst),
                .i_write       (i_src1_write),
                .i_data        (i_src1_data),
                .i_read        (pop),
                .o_data        (src1_head),
                .o_full        (o_src1_full),
                .o_almost_full (),
                .o_empty       (src1_empty)
        );

        pixel_fifo #(.DEPTH(DEPTH), .ALMOST_GAP(ALMOST_GAP)) u_src2_fifo (
                .i_wire_clock  (i_wire_clock),
                .i_rst         (i_rst),
                .i_write       (i_src2_write),
                .i_data        (i_src2_data),
                .i_read        (pop),
                .o_data        (src2_head),
                .o_full        (o_src2_full),
                .o_almost_full (),
                .o_empty       (src2_empty)
        );

        //////////////////////////////////////////////////
        // blend pipeline
        //////////////////////////////////////////////////

        // only the low byte of the blend register is the global alpha
        blend_multiply u_blend_multiply (
                .i_wire_clock      (i_wire_clock),
                .i_rst             (i_rst),
                .i_argb_mode       (i_argb_mode),
                .i_blend_alpha     (i_blend[CHAN_W-1:0]),
                .i_src1            (src1_head),
                .i_src2            (src2_head),
                .i_src1_empty      (src1_empty),
                .i_src2_empty      (src2_empty),
                .i_out_almost_full (out_almost_full),
                .o_pop             (pop),
                .o_prod1           (prod1),
                .o_prod2           (prod2),
                .o_alpha           (alpha),
                .o_valid           (valid)
        );

        blend_combine u_blend_combine (
                .i_wire_clock (i_wire_clock),
                .i_rst        (i_rst),
                .i_argb_mode  (i_argb_mode),
                .i_prod1      (prod1),
                .i_prod2      (prod2),
                .i_alpha      (alpha),
                .i_valid      (valid),
                .o_write      (out_write),
                .o_data       (out_word)
        );

        // output fifo, almost full leaves room for the two words in flight
        pixel_fifo #(.DEPTH(DEPTH), .ALMOST_GAP(ALMOST_GAP)) u_out_fifo (
                .i_wire_clock  (i_wire_clock),
                .i_rst         (i_rst),
                .i_write       (out_write),
                .i_data        (out_word),
                .i_read        (i_out_read),
                .o_data        (o_out_data),
                .o_full        (),
                .o_almost_full (out_almost_full),
                .o_empty       (o_out_empty)
        );

endmodule

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ns

module clock_gen #(
        parameter int HALF_NS    = 4,
        parameter int RST_CYCLES = 3
) (
        output logic o_clk,
        output logic o_rst
);

        initial begin
                o_clk = 1'b0;
                forever #(HALF_NS) o_clk = ~o_clk;
        end

        // release on a falling edge, clear of the sampling edge
        initial begin
                o_rst = 1'b1;
                repeat (RST_CYCLES) @(posedge o_clk);
                @(negedge o_clk);
                o_rst = 1'b0;
        end

endmodule

// ==== bench/render_blend_assert.sv ====
`timescale 1ns/1ns

module render_blend_assert
        import render_pkg::*;
(
        input  logic        i_wire_clock,
        input  logic        i_rst,
        input  logic        i_write,
        input  logic        i_read,
        input  pixel_word_t i_data,
        input  logic        i_full,
        input  logic        i_empty
);

        // writer has to respect full
        a_no_write_full: assert property (@(posedge i_wire_clock) disable iff (i_rst)
                !(i_write && i_full)) else $error("write into a full fifo");

        a_no_read_empty: assert property (@(posedge i_wire_clock) disable iff (i_rst)
                !(i_read && i_empty)) else $error("read from an empty fifo");

        // head word must be known whenever it is popped
        a_known_pop: assert property (@(posedge i_wire_clock) disable iff (i_rst)
                i_read |-> !$isunknown(i_data)) else $error("pop of unknown fifo data");

endmodule

bind pixel_fifo render_blend_assert u_fifo_assert (
        .i_wire_clock (i_wire_clock),
        .i_rst        (i_rst),
        .i_write      (i_write),
        .i_read       (i_read),
        .i_data       (o_data),
        .i_full       (o_full),
        .i_empty      (o_empty)
);

// ==== bench/render_blend_tb.sv ====
`timescale 1ns/1ns

module render_blend_tb
        import render_pkg::*;
;

        localparam int N_ARGB          = 64;
        localparam int N_RGB           = 64;
        localparam int N_STALL         = 40;
        localparam int TOTAL_WORDS     = N_ARGB + N_RGB + N_STALL;
        localparam int WATCHDOG_CYCLES = 40 * TOTAL_WORDS + 1000;

        logic                clk;
        logic                rst;
        logic                i_argb_mode;
        logic [PIXEL_W-1:0]  i_blend;
        logic                i_src1_write;
        pixel_word_t         i_src1_data;
        logic                o_src1_full;
        logic                i_src2_write;
        pixel_word_t         i_src2_data;
        logic                o_src2_full;
        logic                i_out_read;
        pixel_word_t         o_out_data;
        logic                o_out_empty;

        integer              seed = 32'h5ef;
        integer              rd_seed;
        logic                hold_read;
        pixel_word_t         q1[$];
        pixel_word_t         q2[$];
        pixel_word_t         exp_q[$];
        int                  n_pairs;
        int                  n_out;
        int                  n_val_err;
        int                  n_other_err;

        clock_gen u_clock_gen (
                .o_clk (clk),
                .o_rst (rst)
        );

        render_blend_top #(.DEPTH(16), .ALMOST_GAP(2)) i_render_blend_top (
                .i_wire_clock (clk),
                .i_rst        (rst),
                .i_argb_mode  (i_argb_mode),
                .i_blend      (i_blend),
                .i_src1_write (i_src1_write),
                .i_src1_data  (i_src1_data),
                .o_src1_full  (o_src1_full),
                .i_src2_write (i_src2_write),
                .i_src2_data  (i_src2_data),
                .o_src2_full  (o_src2_full),
                .i_out_read   (i_out_read),
                .o_out_data   (o_out_data),
                .o_out_empty  (o_out_empty)
        );

        //////////////////////////////////////////////////
        // reference model
        //////////////////////////////////////////////////

        // c1*a + c2*(256-a), high byte kept
        function automatic logic [7:0] weigh_channel(
                input logic [7:0] c1,
                input logic [7:0] c2,
                input logic [7:0] a
        );
                int t;
                t = int'(c1) * int'(a) + int'(c2) * (ALPHA_ONE - int'(a));
                return 8'(t >> 8);
        endfunction

        // an alpha of zero gives source 2 back untouched
        function automatic pixel_word_t blend_ref(
                input pixel_word_t s1,
                input pixel_word_t s2,
                input logic        argb,
                input logic [7:0]  a
        );
                pixel_word_t r;
                r = '0;
                if (argb) begin
                        r.argb.a = s1.argb.a;
                        r.argb.r = weigh_channel(s1.argb.r, s2.argb.r, s1.argb.a);
                        r.argb.g = weigh_channel(s1.argb.g, s2.argb.g, s1.argb.a);
                        r.argb.b = weigh_channel(s1.argb.b, s2.argb.b, s1.argb.a);
                end else begin
                        r.rgb.hi.r = 5'(weigh_channel(8'(s1.rgb.hi.r), 8'(s2.rgb.hi.r), a));
                        r.rgb.hi.g = 6'(weigh_channel(8'(s1.rgb.hi.g), 8'(s2.rgb.hi.g), a));
                        r.rgb.hi.b = 5'(weigh_channel(8'(s1.rgb.hi.b), 8'(s2.rgb.hi.b), a));
                        r.rgb.lo.r = 5'(weigh_channel(8'(s1.rgb.lo.r), 8'(s2.rgb.lo.r), a));
                        r.rgb.lo.g = 6'(weigh_channel(8'(s1.rgb.lo.g), 8'(s2.rgb.lo.g), a));
                        r.rgb.lo.b = 5'(weigh_channel(8'(s1.rgb.lo.b), 8'(s2.rgb.lo.b), a));
                end
                return r;
        endfunction

        task automatic check_pixel(input pixel_word_t got, input pixel_word_t exp);
                if (got !== exp) begin
                        $display("[FAIL] %0t: pixel %h, expected %h", $time, got, exp);
                        n_val_err++;
                end
        endtask

        task automatic check_flag(input string name, input logic got, input logic exp);
                if (got !== exp) begin
                        $display("[FAIL] %0t: %s is %b, expected %b", $time, name, got, exp);
                        n_val_err++;
                end
        endtask

        // n-th word of source 1 meets n-th word of source 2
        task automatic pair_up();
                while (q1.size() != 0 && q2.size() != 0) begin
                        exp_q.push_back(blend_ref(q1.pop_front(), q2.pop_front(),
                                                  i_argb_mode, i_blend[7:0]));
                        n_pairs++;
                end
        endtask

        // sources written at unequal rates, never into a full fifo
        task automatic send_words(input int n, input logic argb);
                int          sent1;
                int          sent2;
                pixel_word_t w;
                sent1 = 0;
                sent2 = 0;
                while (sent1 < n || sent2 < n) begin
                        @(negedge clk);
                        i_src1_write = 1'b0;
                        i_src2_write = 1'b0;
                        if (sent1 < n && !o_src1_full && ($random(seed) & 3) != 0) begin
                                w = $random(seed);
                                if (argb && sent1 % 8 == 0) begin
                                        w.argb.a = 8'h00;
                                end
                                i_src1_data  = w;
                                i_src1_write = 1'b1;
                                q1.push_back(w);
                                sent1++;
                        end
                        if (sent2 < n && !o_src2_full && ($random(seed) & 1) != 0) begin
                                w = $random(seed);
                                i_src2_data  = w;
                                i_src2_write = 1'b1;
                                q2.push_back(w);
                                sent2++;
                        end
                        pair_up();
                end
                @(negedge clk);
                i_src1_write = 1'b0;
                i_src2_write = 1'b0;
        endtask

        task automatic drain();
                while (exp_q.size() != 0) @(negedge clk);
                repeat (4) @(negedge clk);
                check_flag("o_out_empty after drain", o_out_empty, 1'b1);
        endtask

        //////////////////////////////////////////////////
        // output reader and compare
        //////////////////////////////////////////////////

        initial begin
                i_out_read = 1'b0;
                rd_seed    = seed + 1;
                forever begin
                        @(negedge clk);
                        i_out_read = 1'b0;
                        if (!rst && !hold_read && !o_out_empty &&
                            ($random(rd_seed) & 3) != 0) begin
                                if (exp_q.size() == 0) begin
                                        $display("DUT produced a word that was never sent");
                                        n_other_err++;
                                end else begin
                                        check_pixel(o_out_data, exp_q.pop_front());
                                end
                                n_out++;
                                i_out_read = 1'b1;
                        end
                end
        end

        initial begin
                repeat (WATCHDOG_CYCLES) @(posedge clk);
                $display("watchdog expired before all words came out");
                $display("Test failed");
                $finish;
        end

        initial begin
                i_argb_mode  = 1'b1;
                i_blend      = '0;
                i_src1_write = 1'b0;
                i_src1_data  = '0;
                i_src2_write = 1'b0;
                i_src2_data  = '0;
                hold_read    = 1'b0;
                n_pairs      = 0;
                n_out        = 0;
                n_val_err    = 0;
                n_other_err  = 0;
                @(negedge clk);
                while (rst) @(negedge clk);
                check_flag("o_out_empty after reset", o_out_empty, 1'b1);
                check_flag("o_src1_full after reset", o_src1_full, 1'b0);
                check_flag("o_src2_full after reset", o_src2_full, 1'b0);

                send_words(N_ARGB, 1'b1);
                drain();

                i_argb_mode = 1'b0;
                i_blend     = $random(seed);
                send_words(N_RGB, 1'b0);
                drain();

                // long read pause fills the output and then the sources
                i_argb_mode = 1'b1;
                hold_read   = 1'b1;
                fork
                        send_words(N_STALL, 1'b1);
                        begin : stall_release
                                int k;
                                k = 0;
                                while (!o_src1_full && k < 200) begin
                                        @(negedge clk);
                                        k++;
                                end
                                check_flag("o_src1_full during stall", o_src1_full, 1'b1);
                                repeat (20) @(negedge clk);
                                hold_read = 1'b0;
                        end
                join
                drain();

                if (n_out != n_pairs) begin
                        $display("word count mismatch, %0d out and %0d in", n_out, n_pairs);
                        n_other_err++;
                end
                $display("errors: %0d wrong values, %0d other", n_val_err, n_other_err);
                if (n_val_err == 0 && n_other_err == 0) begin
                        $display("Test passed");
                end else begin
                        $display("Test failed");
                end
                $finish;
        end

endmodule

// ==== render_blend_top.f ====
rtl/render_pkg.sv
rtl/pixel_fifo.sv
rtl/blend_multiply.sv
rtl/blend_combine.sv
rtl/render_blend_top.sv
bench/clock_gen.sv
bench/render_blend_assert.sv
bench/render_blend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the render blend testbench with verilator, run it, then search the log
verilator --binary --timing --assert --top-module render_blend_tb \
        -f render_blend_top.f -Mdir obj_dir > build.log 2>&1 ||
        { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vrender_blend_tb > sim.log 2>&1 ; cat sim.log
grep -qx "Test passed" sim.log && echo "simulation ok" ||
        { echo "simulation did not pass"; exit 1; }
